// File: src/nbr_info_pkg.sv
package nbr_info_pkg;

    // sizing
    localparam int num_banks   = 4;
    localparam int max_node    = 64;
    localparam int max_replay  = 4;
    localparam int num_edge_pe = 4;
    localparam int info_w      = 17;
    localparam int fifo_depth  = 8;

    // one region of max_node/num_banks rows per replay iteration
    localparam int bank_depth  = (max_node / num_banks) * max_replay;

    // derived field widths
    localparam int node_w     = $clog2(max_node);
    localparam int tag_w      = $clog2(num_edge_pe);
    localparam int iter_w     = $clog2(max_replay);
    localparam int bank_sel_w = $clog2(num_banks);
    localparam int row_w      = $clog2(bank_depth);
    localparam int fifo_idx_w = $clog2(fifo_depth);
    localparam int req_w      = node_w + tag_w + iter_w;

    typedef logic [node_w-1:0]     node_id_t;
    typedef logic [tag_w-1:0]      pe_tag_t;
    typedef logic [iter_w-1:0]     replay_iter_t;
    typedef logic [bank_sel_w-1:0] bank_sel_t;
    typedef logic [row_w-1:0]      row_addr_t;   // {iter, node / num_banks}
    typedef logic [info_w-1:0]     info_t;

    // fifo entry laid out as {node, tag, iter}
    typedef logic [req_w-1:0]      req_t;

    typedef enum logic [1:0] {
        idle,
        issue,
        wait_data
    } ctrl_state_t;

endpackage

// File: src/nbr_bank_if.sv
`timescale 1ns/1ps

// one SRAM bank port, controller side to bank side
interface nbr_bank_if;

    logic                    cen;    // active high here
    logic                    wen;    // 1 = write, 0 = read
    nbr_info_pkg::row_addr_t row;
    nbr_info_pkg::info_t     wdata;
    nbr_info_pkg::info_t     rdata;  // registered in the bank

    modport ctrl (
        output cen,
        output wen,
        output row,
        output wdata,
        input  rdata
    );

    modport bank (
        input  cen,
        input  wen,
        input  row,
        input  wdata,
        output rdata
    );

endinterface

// File: src/nbr_req_fifo.sv
`timescale 1ns/1ps

module nbr_req_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  nbr_info_pkg::req_t wr_data,
    input  logic               pop,
    output nbr_info_pkg::req_t rd_data,
    output logic               full,
    output logic               empty
);

    nbr_info_pkg::req_t entries [nbr_info_pkg::fifo_depth];

    // extra msb tells a wrapped pointer from an equal one
    logic [nbr_info_pkg::fifo_idx_w:0]   wr_ptr;
    logic [nbr_info_pkg::fifo_idx_w:0]   rd_ptr;
    logic [nbr_info_pkg::fifo_idx_w-1:0] wr_idx;
    logic [nbr_info_pkg::fifo_idx_w-1:0] rd_idx;

    assign wr_idx = wr_ptr[nbr_info_pkg::fifo_idx_w-1:0];
    assign rd_idx = rd_ptr[nbr_info_pkg::fifo_idx_w-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin  // only raised with a valid head
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_idx] <= wr_data;
        end
    end

    // head is visible right after the write edge
    assign rd_data = entries[rd_idx];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[nbr_info_pkg::fifo_idx_w] != rd_ptr[nbr_info_pkg::fifo_idx_w])
                && (wr_idx == rd_idx);

endmodule

// File: src/nbr_info_bank.sv
`timescale 1ns/1ps

module nbr_info_bank (
    input logic      clk,
    nbr_bank_if.bank mem
);

    // contents come from the load port only
    nbr_info_pkg::info_t words [nbr_info_pkg::bank_depth];

    always_ff @(posedge clk) begin
        if (mem.cen) begin
            if (mem.wen) begin
                words[mem.row] <= mem.wdata;
            end else begin
                mem.rdata <= words[mem.row];  // one cycle read latency
            end
        end
    end

endmodule

// File: src/nbr_info_ctrl.sv
`timescale 1ns/1ps

module nbr_info_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    // request fifo head
    input  nbr_info_pkg::req_t         head,
    input  logic                       empty,
    output logic                       pop,
    // load port
    input  logic                       load_valid,
    output logic                       load_ready,
    input  nbr_info_pkg::node_id_t     load_node,
    input  nbr_info_pkg::replay_iter_t load_iter,
    input  nbr_info_pkg::info_t        load_info,
    // bank ports
    nbr_bank_if.ctrl                   banks [nbr_info_pkg::num_banks],
    // towards the neighbor-id fifo
    output logic                       out_valid,
    input  logic                       out_ready,
    output nbr_info_pkg::info_t        out_info,
    output nbr_info_pkg::pe_tag_t      out_tag
);

    nbr_info_pkg::ctrl_state_t  state;
    nbr_info_pkg::ctrl_state_t  state_nxt;

    nbr_info_pkg::node_id_t     head_node;
    nbr_info_pkg::pe_tag_t      head_tag;
    nbr_info_pkg::replay_iter_t head_iter;

    logic                       acc_wr;
    logic                       acc_rd;
    logic                       out_free;
    nbr_info_pkg::bank_sel_t    acc_bank;
    nbr_info_pkg::row_addr_t    acc_row;

    nbr_info_pkg::bank_sel_t    rd_bank;  // bank of the read in flight
    nbr_info_pkg::pe_tag_t      rd_tag;
    nbr_info_pkg::info_t        bank_rdata [nbr_info_pkg::num_banks];

    // id modulo bank count, power of two so just the low bits
    function automatic nbr_info_pkg::bank_sel_t bank_of(input nbr_info_pkg::node_id_t node);
        return node[nbr_info_pkg::bank_sel_w-1:0];
    endfunction

    // iteration picks the region, id / bank count picks the row in it
    function automatic nbr_info_pkg::row_addr_t row_of(
        input nbr_info_pkg::replay_iter_t iter,
        input nbr_info_pkg::node_id_t     node
    );
        return {iter, node[nbr_info_pkg::node_w-1:nbr_info_pkg::bank_sel_w]};
    endfunction

    assign head_node = head[nbr_info_pkg::req_w-1 -: nbr_info_pkg::node_w];
    assign head_tag  = head[nbr_info_pkg::iter_w +: nbr_info_pkg::tag_w];
    assign head_iter = head[nbr_info_pkg::iter_w-1:0];

    // output register empty now or emptied at this edge
    assign out_free = !out_valid || out_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            nbr_info_pkg::idle: begin
                // a pending load keeps us here for its write cycle
                if (!(load_valid && load_ready) && !empty && out_free) begin
                    state_nxt = nbr_info_pkg::issue;
                end
            end
            nbr_info_pkg::issue:     state_nxt = nbr_info_pkg::wait_data;
            nbr_info_pkg::wait_data: state_nxt = nbr_info_pkg::idle;
            default:                 state_nxt = nbr_info_pkg::idle;
        endcase
    end

    // load_ready only ever high in idle
    assign acc_wr = load_valid && load_ready;
    assign acc_rd = (state == nbr_info_pkg::issue);
    assign pop    = acc_rd;

    assign acc_bank = acc_wr ? bank_of(load_node) : bank_of(head_node);
    assign acc_row  = acc_wr ? row_of(load_iter, load_node) : row_of(head_iter, head_node);

    for (genvar g = 0; g < nbr_info_pkg::num_banks; g++) begin : g_bank
        assign banks[g].cen   = (acc_wr || acc_rd)
                             && (acc_bank == nbr_info_pkg::bank_sel_t'(g));
        assign banks[g].wen   = acc_wr;
        assign banks[g].row   = acc_row;
        assign banks[g].wdata = load_info;
        assign bank_rdata[g]  = banks[g].rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= nbr_info_pkg::idle;
            load_ready <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            state      <= state_nxt;
            load_ready <= (state_nxt == nbr_info_pkg::idle);
            if (state == nbr_info_pkg::wait_data) begin
                out_valid <= 1'b1;  // slot was freed before the issue
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_rd) begin
            rd_bank <= acc_bank;
            rd_tag  <= head_tag;
        end
        if (state == nbr_info_pkg::wait_data) begin
            out_info <= bank_rdata[rd_bank];
            out_tag  <= rd_tag;
        end
    end

endmodule

// File: src/nbr_info_mem.sv
`timescale 1ns/1ps

module nbr_info_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    // lookup requests from the edge PEs
    input  logic                       req_valid,
    output logic                       req_ready,
    input  nbr_info_pkg::node_id_t     req_node,
    input  nbr_info_pkg::pe_tag_t      req_tag,
    input  nbr_info_pkg::replay_iter_t req_iter,
    // one word per (iteration, node)
    input  logic                       load_valid,
    output logic                       load_ready,
    input  nbr_info_pkg::node_id_t     load_node,
    input  nbr_info_pkg::replay_iter_t load_iter,
    input  nbr_info_pkg::info_t        load_info,
    // to the neighbor-id fifo
    output logic                       out_valid,
    input  logic                       out_ready,  // not full downstream
    output nbr_info_pkg::info_t        out_info,
    output nbr_info_pkg::pe_tag_t      out_tag
);

    logic               req_push;
    logic               fifo_full;
    logic               fifo_empty;
    logic               fifo_pop;
    nbr_info_pkg::req_t fifo_head;

    nbr_bank_if bank_bus [nbr_info_pkg::num_banks] ();

    assign req_ready = !fifo_full;
    assign req_push  = req_valid && req_ready;

    // iteration sampled together with the request
    nbr_req_fifo u_req_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (req_push),
        .wr_data ({req_node, req_tag, req_iter}),
        .pop     (fifo_pop),
        .rd_data (fifo_head),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    nbr_info_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (fifo_head),
        .empty      (fifo_empty),
        .pop        (fifo_pop),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_node  (load_node),
        .load_iter  (load_iter),
        .load_info  (load_info),
        .banks      (bank_bus),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_info   (out_info),
        .out_tag    (out_tag)
    );

    // interleaved banks, node id low bits select one
    for (genvar g = 0; g < nbr_info_pkg::num_banks; g++) begin : g_bank
        nbr_info_bank u_bank (
            .clk (clk),
            .mem (bank_bus[g])
        );
    end

endmodule

// File: bench/nbr_info_checker.sv
`timescale 1ns/1ps

module nbr_info_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  req_valid,
    input logic                  req_ready,
    input logic                  fifo_pop,
    input logic                  fifo_empty,
    input logic                  out_valid,
    input logic                  out_ready,
    input nbr_info_pkg::info_t   out_info,
    input nbr_info_pkg::pe_tag_t out_tag
);

    int errors = 0;  // failed checks so far
    int fifo_count;  // entries the FIFO should hold

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_count <= 0;
        end else begin
            fifo_count <= fifo_count + int'(req_valid && req_ready) - int'(fifo_pop);
        end
    end

    // reset seen at one edge keeps out_valid low up to the next
    out_low_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            errors++;
            $error("out_valid high while rst_n is low");
        end

    out_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> ($stable(out_info) && $stable(out_tag)))
        else begin
            errors++;
            $error("out_info or out_tag changed under back-pressure");
        end

    out_held_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> out_valid)
        else begin
            errors++;
            $error("out_valid dropped before the result was taken");
        end

    // a transfer needs room in the FIFO
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready) |-> (fifo_count < nbr_info_pkg::fifo_depth))
        else begin
            errors++;
            $error("request accepted while the FIFO was full");
        end

    // controller only acknowledges a real head entry
    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_pop |-> !fifo_empty)
        else begin
            errors++;
            $error("request FIFO popped while empty");
        end

endmodule

bind nbr_info_mem nbr_info_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .fifo_pop   (fifo_pop),
    .fifo_empty (fifo_empty),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_info   (out_info),
    .out_tag    (out_tag)
);

// File: bench/tb_nbr_info_mem.sv
`timescale 1ns/1ps

module tb_nbr_info_mem;

    localparam int cycle_limit = 3000;  // 256 loads + ~4 cycles per request, with slack

    logic                       clk;
    logic                       rst_n;
    logic                       req_valid;
    logic                       req_ready;
    nbr_info_pkg::node_id_t     req_node;
    nbr_info_pkg::pe_tag_t      req_tag;
    nbr_info_pkg::replay_iter_t req_iter;
    logic                       load_valid;
    logic                       load_ready;
    nbr_info_pkg::node_id_t     load_node;
    nbr_info_pkg::replay_iter_t load_iter;
    nbr_info_pkg::info_t        load_info;
    logic                       out_valid;
    logic                       out_ready;
    nbr_info_pkg::info_t        out_info;
    nbr_info_pkg::pe_tag_t      out_tag;

    integer seed = 29896;
    int     cycles;
    int     accepted;
    logic   stall_mode;  // random out_ready drops
    logic   hold_out;    // out_ready forced low

    // reference contents, [iteration][node]
    nbr_info_pkg::info_t   model [nbr_info_pkg::max_replay][nbr_info_pkg::max_node];
    nbr_info_pkg::info_t   exp_info_q [$];
    nbr_info_pkg::pe_tag_t exp_tag_q [$];

    nbr_info_mem uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_node   (req_node),
        .req_tag    (req_tag),
        .req_iter   (req_iter),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_node  (load_node),
        .load_iter  (load_iter),
        .load_info  (load_info),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_info   (out_info),
        .out_tag    (out_tag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic run_error(input string what);
        $display("ERROR: %s", what);
        stop_failed();
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("FAIL %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        stop_failed();
    endtask

    // word tied to its whole address, random upper bits
    function automatic nbr_info_pkg::info_t make_word(input nbr_info_pkg::replay_iter_t iter,
                                                      input nbr_info_pkg::node_id_t node);
        logic [31:0] r;
        r = $random(seed);
        return {r[8:0], iter, node};
    endfunction

    // step to 2 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (hold_out) begin
            out_ready = 1'b0;
        end else if (stall_mode) begin
            out_ready = ({$random(seed)} % 3) != 0;
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic request_node(input nbr_info_pkg::node_id_t node,
                                input nbr_info_pkg::pe_tag_t tag,
                                input nbr_info_pkg::replay_iter_t iter);
        req_valid = 1'b1;
        req_node  = node;
        req_tag   = tag;
        req_iter  = iter;
        @(negedge clk);
        while (!req_ready) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic random_request();
        nbr_info_pkg::node_id_t     node;
        nbr_info_pkg::pe_tag_t      tag;
        nbr_info_pkg::replay_iter_t iter;
        node = nbr_info_pkg::node_id_t'($random(seed));
        tag  = nbr_info_pkg::pe_tag_t'($random(seed));
        iter = nbr_info_pkg::replay_iter_t'($random(seed));
        request_node(node, tag, iter);
    endtask

    task automatic load_entry(input nbr_info_pkg::replay_iter_t iter,
                              input nbr_info_pkg::node_id_t node,
                              input nbr_info_pkg::info_t info);
        load_valid = 1'b1;
        load_iter  = iter;
        load_node  = node;
        load_info  = info;
        @(negedge clk);
        while (!load_ready) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        load_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_info_q.size() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    // scoreboard, sampled mid-cycle where everything is settled
    initial begin
        nbr_info_pkg::info_t   exp_info;
        nbr_info_pkg::pe_tag_t exp_tag;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                assert (uut.u_checker.errors == 0)
                    else run_error("protocol checker flagged a violation");
                if (load_valid && load_ready) begin
                    model[load_iter][load_node] = load_info;
                end
                if (req_valid && req_ready) begin
                    exp_info_q.push_back(model[req_iter][req_node]);
                    exp_tag_q.push_back(req_tag);
                end
                if (out_valid && out_ready) begin
                    assert (exp_info_q.size() != 0)
                        else run_error("result delivered with no request outstanding");
                    exp_info = exp_info_q.pop_front();
                    exp_tag  = exp_tag_q.pop_front();
                    assert (out_info === exp_info) else value_error("out_info", exp_info, out_info);
                    assert (out_tag === exp_tag) else value_error("out_tag", exp_tag, out_tag);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        run_error($sformatf("timeout, no finish within %0d cycles", cycle_limit));
    end

    initial begin
        nbr_info_pkg::node_id_t probe;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_node   = '0;
        req_tag    = '0;
        req_iter   = '0;
        load_valid = 1'b0;
        load_node  = '0;
        load_iter  = '0;
        load_info  = '0;
        out_ready  = 1'b1;
        stall_mode = 1'b0;
        hold_out   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        // handshakes while in reset
        assert (load_ready === 1'b0) else value_error("load_ready", 0, load_ready);
        assert (req_ready === 1'b1) else value_error("req_ready", 1, req_ready);
        @(posedge clk);
        #2 rst_n = 1'b1;
        next_cycle();

        // fill all regions, then read iteration 0 back
        for (int it = 0; it < nbr_info_pkg::max_replay; it++) begin
            for (int n = 0; n < nbr_info_pkg::max_node; n++) begin
                load_entry(it, n, make_word(it, n));
            end
        end
        for (int n = 0; n < nbr_info_pkg::max_node; n++) begin
            request_node(n, nbr_info_pkg::pe_tag_t'($random(seed)), 0);
        end
        wait_drain();

        // consecutive ids walk across all banks
        for (int n = 0; n < 16; n++) begin
            request_node(n, nbr_info_pkg::pe_tag_t'(n), 2);
        end
        wait_drain();

        // one node under every iteration, iteration bits keep the words apart
        probe = nbr_info_pkg::node_id_t'($random(seed));
        for (int it = 0; it < nbr_info_pkg::max_replay; it++) begin
            request_node(probe, nbr_info_pkg::pe_tag_t'(it), it);
        end
        wait_drain();

        stall_mode = 1'b1;
        repeat (40) random_request();
        wait_drain();
        stall_mode = 1'b0;

        // fill the FIFO behind a held result
        hold_out = 1'b1;
        next_cycle();
        accepted  = 0;
        req_valid = 1'b1;
        req_node  = nbr_info_pkg::node_id_t'($random(seed));
        req_tag   = nbr_info_pkg::pe_tag_t'($random(seed));
        req_iter  = nbr_info_pkg::replay_iter_t'($random(seed));
        @(negedge clk);
        while (req_ready && accepted <= nbr_info_pkg::fifo_depth + 2) begin
            next_cycle();
            accepted++;
            req_node = nbr_info_pkg::node_id_t'($random(seed));
            req_tag  = nbr_info_pkg::pe_tag_t'($random(seed));
            req_iter = nbr_info_pkg::replay_iter_t'($random(seed));
            @(negedge clk);
        end
        assert (accepted <= nbr_info_pkg::fifo_depth + 2)
            else run_error("req_ready stayed high with the output held");
        next_cycle();
        req_valid = 1'b0;
        hold_out  = 1'b0;
        wait_drain();

        // load jumps ahead of queued lookups
        probe = 40;
        for (int n = 0; n < 4; n++) begin
            request_node(n, nbr_info_pkg::pe_tag_t'(3 - n), 1);
        end
        load_entry(3, probe, model[3][probe] ^ {9'h1ff, 8'h00});
        assert (exp_info_q.size() != 0)
            else run_error("load only completed after the pending lookups");
        request_node(probe, 2'd1, 3);
        wait_drain();

        if (!out_valid) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            run_error("out_valid still high after every request was answered");
        end
    end

endmodule

// File: tb.f
src/nbr_info_pkg.sv
src/nbr_bank_if.sv
src/nbr_req_fifo.sv
src/nbr_info_bank.sv
src/nbr_info_ctrl.sv
src/nbr_info_mem.sv
bench/nbr_info_checker.sv
bench/tb_nbr_info_mem.sv

// File: Bender.yml
package:
  name: nbr_info_mem

sources:
  - src/nbr_info_pkg.sv
  - src/nbr_bank_if.sv
  - src/nbr_req_fifo.sv
  - src/nbr_info_bank.sv
  - src/nbr_info_ctrl.sv
  - src/nbr_info_mem.sv
  - target: test
    files:
      - bench/nbr_info_checker.sv
      - bench/tb_nbr_info_mem.sv
